//--- design/cache_addr_pkg.sv
package cache_addr_pkg;

    // Geometry of a 32-bit byte address
    localparam int TAG_BITS    = 23;
    localparam int INDEX_BITS  = 4;
    localparam int OFFSET_BITS = 5;

    localparam int WAYS      = 4;
    localparam int LINE_BITS = 256;
    localparam int WORD_BITS = 32;

    typedef struct packed {
        logic [TAG_BITS-1:0]    tag;
        logic [INDEX_BITS-1:0]  index;
        logic [OFFSET_BITS-1:0] offset;
    } addr_fields_t;

    // Raw word for memory, fields for lookup
    typedef union packed {
        logic [WORD_BITS-1:0] raw;
        addr_fields_t         fields;
    } addr_u;

endpackage : cache_addr_pkg

//--- design/cache_arrays.sv
`timescale 1ns/100ps

module cache_arrays
import cache_addr_pkg::*;
#(
    parameter int TAG_SIZE        = TAG_BITS + 1,
    parameter int WAYS            = cache_addr_pkg::WAYS,
    parameter int CACHE_LINE_SIZE = LINE_BITS
)
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [INDEX_BITS-1:0]      index,
    input  logic                       set_ways_valid    [WAYS],
    input  logic                       set_ways_valid_we [WAYS],
    input  logic [TAG_SIZE-1:0]        set_ways_tags     [WAYS],
    input  logic                       set_ways_tags_we  [WAYS],
    input  logic [CACHE_LINE_SIZE-1:0] set_ways_lines    [WAYS],
    input  logic                       set_ways_data_we  [WAYS],
    input  logic                       plru_we,
    input  logic [WAYS-2:0]            set_plru_bits,
    output logic                       ways_valid [WAYS],
    output logic [TAG_SIZE-1:0]        ways_tags  [WAYS],
    output logic [CACHE_LINE_SIZE-1:0] ways_lines [WAYS],
    output logic [WAYS-2:0]            plru_bits
);

    localparam int SETS = 2 ** INDEX_BITS;

    logic                       valid_q [SETS][WAYS];
    logic [TAG_SIZE-1:0]        tag_q   [SETS][WAYS];
    logic [CACHE_LINE_SIZE-1:0] line_q  [SETS][WAYS];
    logic [WAYS-2:0]            plru_q  [SETS];

    // Valid and PLRU state, write enables active low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < SETS; s++) begin
                plru_q[s] <= '0;
                for (int w = 0; w < WAYS; w++) begin
                    valid_q[s][w] <= 1'b0;
                end
            end
        end else begin
            for (int w = 0; w < WAYS; w++) begin
                if (!set_ways_valid_we[w]) begin
                    valid_q[index][w] <= set_ways_valid[w];
                end
            end
            if (!plru_we) begin
                plru_q[index] <= set_plru_bits;
            end
        end
    end

    // Tag and line storage
    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (!set_ways_tags_we[w]) begin
                tag_q[index][w] <= set_ways_tags[w];
            end
            if (!set_ways_data_we[w]) begin
                line_q[index][w] <= set_ways_lines[w];
            end
        end
    end

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            ways_valid[w] = valid_q[index][w];
            ways_tags[w]  = tag_q[index][w];
            ways_lines[w] = line_q[index][w];
        end
        plru_bits = plru_q[index];
    end

endmodule : cache_arrays

//--- design/cache_control.sv
`timescale 1ns/100ps

module cache_control
import cache_types::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   cpu_read,
    input  logic   cpu_write,
    input  logic   valid_hit,
    input  logic   dirty,
    input  logic   mem_resp,
    output state_t state,
    output logic   mem_read,
    output logic   mem_write
);

    state_t next_state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle_s;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            idle_s: begin
                if (cpu_read || cpu_write) begin
                    next_state = compare_tag_s;
                end
            end
            compare_tag_s: begin
                if (valid_hit) begin
                    next_state = idle_s;
                end else if (dirty) begin
                    // Victim must go back to memory first
                    next_state = writeback_s;
                end else begin
                    next_state = allocate_s;
                end
            end
            writeback_s: begin
                if (mem_resp) begin
                    next_state = allocate_s;
                end
            end
            allocate_s: begin
                // Refilled line hits on the second compare
                if (mem_resp) begin
                    next_state = compare_tag_s;
                end
            end
            default: next_state = idle_s;
        endcase
    end

    // Memory requests held for the whole state
    assign mem_write = (state == writeback_s);
    assign mem_read  = (state == allocate_s);

endmodule : cache_control

//--- design/cache_logic.sv
`timescale 1ns/100ps

module cache_logic
import cache_types::*, cache_addr_pkg::*;
#(
    parameter int TAG_SIZE        = TAG_BITS + 1,
    parameter int WAYS            = cache_addr_pkg::WAYS,
    parameter int CACHE_LINE_SIZE = LINE_BITS,
    parameter int READ_SIZE       = WORD_BITS
)
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  state_t                     state,
    input  logic                       cpu_read,
    input  logic                       cpu_write,
    input  logic [TAG_SIZE-2:0]        target_tag,
    input  logic [OFFSET_BITS-1:0]     offset,
    input  logic [READ_SIZE-1:0]       cpu_wdata,
    input  logic [READ_SIZE/8-1:0]     cpu_wmask,
    input  logic [CACHE_LINE_SIZE-1:0] mem_rline,
    input  logic                       mem_resp,
    input  logic                       ways_valid [WAYS],
    input  logic [TAG_SIZE-1:0]        ways_tags  [WAYS],
    input  logic [CACHE_LINE_SIZE-1:0] ways_lines [WAYS],
    input  logic [WAYS-2:0]            plru_bits,
    output logic                       valid_hit,
    output logic                       dirty,
    output logic [READ_SIZE-1:0]       cpu_rdata,
    output logic                       cpu_resp,
    output logic [CACHE_LINE_SIZE-1:0] mem_wline,
    output logic [TAG_SIZE-2:0]        tag_eviction,
    output logic                       set_ways_valid    [WAYS],
    output logic                       set_ways_valid_we [WAYS],
    output logic [TAG_SIZE-1:0]        set_ways_tags     [WAYS],
    output logic                       set_ways_tags_we  [WAYS],
    output logic [CACHE_LINE_SIZE-1:0] set_ways_lines    [WAYS],
    output logic                       set_ways_data_we  [WAYS],
    output logic [WAYS-2:0]            set_plru_bits,
    output logic                       plru_we
);

    localparam int WAY_IDX = $clog2(WAYS);

    way_t                       hit_way;
    way_t                       victim_way;
    way_t                       victim_q;
    way_t                       evict_way;
    logic [WAY_IDX-1:0]         hit_idx;
    logic [WAY_IDX-1:0]         evict_idx;
    logic [READ_SIZE-1:0]       byte_bits;
    logic [CACHE_LINE_SIZE-1:0] wdata_line;
    logic [CACHE_LINE_SIZE-1:0] bit_mask;
    logic [CACHE_LINE_SIZE-1:0] merged_line;
    logic [CACHE_LINE_SIZE-1:0] read_line;

    plru_tree #(.WAYS(WAYS)) u_plru_tree (
        .plru_bits     (plru_bits),
        .hit_way       (hit_way),
        .victim_way    (victim_way),
        .set_plru_bits (set_plru_bits)
    );

    always_comb begin
        valid_hit = 1'b0;
        hit_way   = way_none;
        hit_idx   = '0;
        for (int i = 0; i < WAYS; i++) begin
            if (ways_valid[i] && ways_tags[i][TAG_SIZE-2:0] == target_tag) begin
                valid_hit = 1'b1;
                hit_way   = way_t'(i);
                hit_idx   = WAY_IDX'(i);
            end
        end
    end

    // Victim held from the missing compare through writeback and allocate
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            victim_q <= way_0;
        end else if (state == compare_tag_s && !valid_hit) begin
            victim_q <= victim_way;
        end
    end

    assign evict_way    = (state == compare_tag_s) ? victim_way : victim_q;
    assign evict_idx    = WAY_IDX'(evict_way);
    assign dirty        = ways_valid[evict_idx] && ways_tags[evict_idx][TAG_SIZE-1];
    assign tag_eviction = ways_tags[evict_idx][TAG_SIZE-2:0];
    assign mem_wline    = ways_lines[evict_idx];

    assign cpu_resp = (state == compare_tag_s) && valid_hit;
    assign plru_we  = !cpu_resp;

    // Byte mask widened to bits, then placed at the offset
    always_comb begin
        for (int b = 0; b < READ_SIZE / 8; b++) begin
            byte_bits[8*b +: 8] = {8{cpu_wmask[b]}};
        end
    end

    assign wdata_line  = CACHE_LINE_SIZE'(cpu_wdata) << (8 * offset);
    assign bit_mask    = CACHE_LINE_SIZE'(byte_bits) << (8 * offset);
    assign merged_line = (ways_lines[hit_idx] & ~bit_mask) | (wdata_line & bit_mask);

    assign read_line = ways_lines[hit_idx] >> (8 * offset);
    assign cpu_rdata = (cpu_resp && cpu_read) ? read_line[READ_SIZE-1:0] : '0;

    // Array writes, enables active low
    always_comb begin
        for (int i = 0; i < WAYS; i++) begin
            set_ways_valid[i]    = 1'b1;
            set_ways_valid_we[i] = 1'b1;
            set_ways_tags[i]     = {cpu_write, target_tag};
            set_ways_tags_we[i]  = 1'b1;
            set_ways_lines[i]    = mem_rline;
            set_ways_data_we[i]  = 1'b1;
        end
        if (state == allocate_s && mem_resp) begin
            set_ways_valid_we[evict_idx] = 1'b0;
            set_ways_tags_we[evict_idx]  = 1'b0;
            set_ways_data_we[evict_idx]  = 1'b0;
        end else if (cpu_resp && cpu_write) begin
            set_ways_tags[hit_idx]    = {1'b1, target_tag};
            set_ways_tags_we[hit_idx] = 1'b0;
            set_ways_lines[hit_idx]   = merged_line;
            set_ways_data_we[hit_idx] = 1'b0;
        end
    end

endmodule : cache_logic

//--- design/cache_top.sv
`timescale 1ns/100ps

module cache_top
import cache_types::*, cache_addr_pkg::*;
#(
    parameter int TAG_SIZE        = TAG_BITS + 1,
    parameter int WAYS            = cache_addr_pkg::WAYS,
    parameter int CACHE_LINE_SIZE = LINE_BITS,
    parameter int READ_SIZE       = WORD_BITS
)
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cpu_read,
    input  logic                       cpu_write,
    input  logic [WORD_BITS-1:0]       cpu_addr,
    input  logic [READ_SIZE-1:0]       cpu_wdata,
    input  logic [READ_SIZE/8-1:0]     cpu_wmask,
    input  logic [CACHE_LINE_SIZE-1:0] mem_rline,
    input  logic                       mem_resp,
    output logic [READ_SIZE-1:0]       cpu_rdata,
    output logic                       cpu_resp,
    output logic                       mem_read,
    output logic                       mem_write,
    output logic [WORD_BITS-1:0]       mem_addr,
    output logic [CACHE_LINE_SIZE-1:0] mem_wline
);

    state_t                     state;
    logic                       valid_hit;
    logic                       dirty;
    addr_u                      req_addr;
    addr_u                      line_addr;
    logic [INDEX_BITS-1:0]      index;
    logic [TAG_SIZE-2:0]        target_tag;
    logic [OFFSET_BITS-1:0]     offset;
    logic [TAG_SIZE-2:0]        tag_eviction;
    logic                       ways_valid        [WAYS];
    logic [TAG_SIZE-1:0]        ways_tags         [WAYS];
    logic [CACHE_LINE_SIZE-1:0] ways_lines        [WAYS];
    logic                       set_ways_valid    [WAYS];
    logic                       set_ways_valid_we [WAYS];
    logic [TAG_SIZE-1:0]        set_ways_tags     [WAYS];
    logic                       set_ways_tags_we  [WAYS];
    logic [CACHE_LINE_SIZE-1:0] set_ways_lines    [WAYS];
    logic                       set_ways_data_we  [WAYS];
    logic [WAYS-2:0]            plru_bits;
    logic [WAYS-2:0]            set_plru_bits;
    logic                       plru_we;

    assign req_addr.raw = cpu_addr;
    assign index        = req_addr.fields.index;
    assign target_tag   = req_addr.fields.tag;
    assign offset       = req_addr.fields.offset;

    // Writeback goes to the evicted line, a fill to the request line
    always_comb begin
        line_addr               = req_addr;
        line_addr.fields.offset = '0;
        if (state == writeback_s) begin
            line_addr.fields.tag = tag_eviction;
        end
    end

    assign mem_addr = line_addr.raw;

    cache_control u_cache_control (.*);

    cache_arrays #(
        .TAG_SIZE        (TAG_SIZE),
        .WAYS            (WAYS),
        .CACHE_LINE_SIZE (CACHE_LINE_SIZE)
    ) u_cache_arrays (.*);

    cache_logic #(
        .TAG_SIZE        (TAG_SIZE),
        .WAYS            (WAYS),
        .CACHE_LINE_SIZE (CACHE_LINE_SIZE),
        .READ_SIZE       (READ_SIZE)
    ) u_cache_logic (.*);

endmodule : cache_top

//--- design/cache_types.sv
package cache_types;

    // Controller states
    typedef enum logic [1:0] {
        idle_s,
        compare_tag_s,
        writeback_s,
        allocate_s
    } state_t;

    // Way select, way_none when no way applies
    typedef enum logic [2:0] {
        way_0    = 3'd0,
        way_1    = 3'd1,
        way_2    = 3'd2,
        way_3    = 3'd3,
        way_none = 3'd4
    } way_t;

endpackage : cache_types

//--- design/plru_tree.sv
`timescale 1ns/100ps

module plru_tree
import cache_types::*, cache_addr_pkg::*;
#(
    parameter int WAYS = cache_addr_pkg::WAYS
)
(
    input  logic [WAYS-2:0] plru_bits,
    input  way_t            hit_way,
    output way_t            victim_way,
    output logic [WAYS-2:0] set_plru_bits
);

    localparam int LEVELS = $clog2(WAYS);

    // Heap order, children of node n at 2n+1 and 2n+2
    // A set bit means the victim lies in the right subtree
    always_comb begin
        int node;
        node = 0;
        for (int l = 0; l < LEVELS; l++) begin
            node = 2 * node + 1 + int'(plru_bits[node]);
        end
        victim_way = way_t'(node - (WAYS - 1));
    end

    // Point each node on the touched path away from it
    always_comb begin
        int node;
        int leaf;
        node          = 0;
        leaf          = 0;
        set_plru_bits = plru_bits;
        if (hit_way != way_none) begin
            leaf = int'(hit_way) + WAYS - 1;
            for (int l = 0; l < LEVELS; l++) begin
                node                = (leaf - 1) / 2;
                set_plru_bits[node] = (leaf % 2 == 1);
                leaf                = node;
            end
        end
    end

endmodule : plru_tree

//--- dv/cache_asserts.sv
`timescale 1ns/100ps

module cache_asserts
import cache_types::*;
(
    input logic   clk,
    input logic   rst_n,
    input state_t state,
    input logic   valid_hit,
    input logic   mem_resp,
    input logic   mem_read,
    input logic   mem_write
);

    // cpu_resp rebuilt from the controller's view
    logic resp;

    assign resp = (state == compare_tag_s) && valid_hit;

    resp_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        resp |=> !resp)
        else $error("cpu_resp stayed high for more than one cycle");

    // Memory traffic only ever follows a missing compare
    mem_start: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_read || mem_write) |->
            ($past(state) == compare_tag_s) && !$past(valid_hit))
        else $error("memory request raised without a missing compare");

    mem_held: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_read || mem_write) && !mem_resp |=> $stable({mem_read, mem_write}))
        else $error("memory request changed before mem_resp");

    wb_then_fill: assert property (@(posedge clk) disable iff (!rst_n)
        mem_write && mem_resp |=> mem_read && !mem_write)
        else $error("writeback was not followed by a line fill");

endmodule : cache_asserts

bind cache_control cache_asserts u_cache_asserts (.*);

//--- dv/cache_cases.txt
# op(0 read, 1 write) addr wdata mask expected_rdata traffic
# traffic bit0 a line fill, bit1 a dirty writeback
0 00000000 00000000 0 5a5a0000 1
0 00000004 00000000 0 5a5a0004 0
0 00000200 00000000 0 5a5a0200 1
0 00000400 00000000 0 5a5a0400 1
0 00000600 00000000 0 5a5a0600 1
0 00000800 00000000 0 5a5a0800 1
0 0000000c 00000000 0 5a5a000c 1
0 00000604 00000000 0 5a5a0604 0
1 00000028 11223344 5 00000000 1
0 00000028 00000000 0 5a220044 0
1 0000002c a1b2c3d4 f 00000000 0
0 0000002c 00000000 0 a1b2c3d4 0
0 00000220 00000000 0 5a5a0220 1
0 00000420 00000000 0 5a5a0420 1
0 00000620 00000000 0 5a5a0620 1
0 00000830 00000000 0 5a5a0830 3
0 00000028 00000000 0 5a220044 1
0 0000002c 00000000 0 a1b2c3d4 0
1 12345678 deadbeef 3 00000000 1
0 12345678 00000000 0 486ebeef 0
0 9abcdef0 00000000 0 c0e6def0 1
1 9abcdef4 0f1e2d3c 8 00000000 0
0 9abcdef4 00000000 0 0fe6def4 0
0 9abcdef0 00000000 0 c0e6def0 0
1 000031a4 55aa55aa 6 00000000 1
0 000031a4 00000000 0 5aaa55a4 0

//--- dv/cache_tb.sv
`timescale 1ns/100ps

module cache_tb
import cache_addr_pkg::*;
();

    localparam logic [WORD_BITS-1:0] FILL = 32'h5a5a_0000;
    localparam int LINE_WORDS = LINE_BITS / WORD_BITS;

    logic                   clk;
    logic                   rst_n;
    logic                   cpu_read;
    logic                   cpu_write;
    logic [WORD_BITS-1:0]   cpu_addr;
    logic [WORD_BITS-1:0]   cpu_wdata;
    logic [WORD_BITS/8-1:0] cpu_wmask;
    logic [LINE_BITS-1:0]   mem_rline;
    logic                   mem_resp;
    logic [WORD_BITS-1:0]   cpu_rdata;
    logic                   cpu_resp;
    logic                   mem_read;
    logic                   mem_write;
    logic [WORD_BITS-1:0]   mem_addr;
    logic [LINE_BITS-1:0]   mem_wline;

    // Written-back words; untouched words follow the fill pattern
    logic [WORD_BITS-1:0] mem_words [int unsigned];
    // What the CPU should read back
    logic [WORD_BITS-1:0] shadow [int unsigned];

    logic [3:0]           case_op      [$];
    logic [WORD_BITS-1:0] case_addr    [$];
    logic [WORD_BITS-1:0] case_wdata   [$];
    logic [3:0]           case_mask    [$];
    logic [WORD_BITS-1:0] case_exp     [$];
    logic [1:0]           case_traffic [$];

    int num_cases;
    bit cases_loaded;
    int read_count;
    int write_count;
    int n_checks;
    int n_errors;

    cache_top u_cache_top (.*);

    always #5 clk = ~clk;

    function automatic logic [WORD_BITS-1:0] mem_word(input logic [WORD_BITS-1:0] addr);
        if (mem_words.exists(addr)) begin
            return mem_words[addr];
        end
        return addr ^ FILL;
    endfunction

    function automatic logic [WORD_BITS-1:0] shadow_word(input logic [WORD_BITS-1:0] addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return addr ^ FILL;
    endfunction

    function automatic logic [LINE_BITS-1:0] memory_line(input logic [WORD_BITS-1:0] base);
        logic [LINE_BITS-1:0] line;
        for (int i = 0; i < LINE_WORDS; i++) begin
            line[WORD_BITS*i +: WORD_BITS] = mem_word(base + 4 * i);
        end
        return line;
    endfunction

    function automatic logic [LINE_BITS-1:0] shadow_line(input logic [WORD_BITS-1:0] base);
        logic [LINE_BITS-1:0] line;
        for (int i = 0; i < LINE_WORDS; i++) begin
            line[WORD_BITS*i +: WORD_BITS] = shadow_word(base + 4 * i);
        end
        return line;
    endfunction

    task automatic check_rdata(input logic [WORD_BITS-1:0] got,
                               input logic [WORD_BITS-1:0] exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED at %0t: %s read %08h, expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic check_line(input logic [WORD_BITS-1:0] addr,
                              input logic [LINE_BITS-1:0] got);
        logic [LINE_BITS-1:0] exp;
        exp = shadow_line(addr);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED at %0t: writeback of line %08h is %064h, expected %064h",
                     $time, addr, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED at %0t: %s is %0b, expected %0b", $time, what, got, exp);
        end
    endtask

    task automatic update_shadow(input logic [WORD_BITS-1:0] addr,
                                 input logic [WORD_BITS-1:0] wdata, input logic [3:0] mask);
        logic [WORD_BITS-1:0] word_addr;
        logic [WORD_BITS-1:0] word;
        // Cases use word-aligned addresses
        word_addr = {addr[WORD_BITS-1:2], 2'b00};
        word      = shadow_word(word_addr);
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                word[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        shadow[word_addr] = word;
    endtask

    task automatic run_case(input int idx);
        int                   reads_before;
        int                   writes_before;
        logic [WORD_BITS-1:0] got;
        reads_before  = read_count;
        writes_before = write_count;
        @(posedge clk);
        #1;
        cpu_read  = (case_op[idx] == 4'd0);
        cpu_write = (case_op[idx] != 4'd0);
        cpu_addr  = case_addr[idx];
        cpu_wdata = case_wdata[idx];
        cpu_wmask = case_mask[idx];
        @(negedge clk);
        while (!cpu_resp) begin
            @(negedge clk);
        end
        got = cpu_rdata;
        @(posedge clk);
        #1;
        cpu_read  = 1'b0;
        cpu_write = 1'b0;
        if (case_op[idx] == 4'd0) begin
            check_rdata(got, case_exp[idx], $sformatf("case %0d", idx));
            check_rdata(got, shadow_word({case_addr[idx][WORD_BITS-1:2], 2'b00}),
                        $sformatf("case %0d against shadow", idx));
        end else begin
            update_shadow(case_addr[idx], case_wdata[idx], case_mask[idx]);
        end
        check_flag(read_count != reads_before, case_traffic[idx][0],
                   $sformatf("case %0d line fill", idx));
        check_flag(write_count != writes_before, case_traffic[idx][1],
                   $sformatf("case %0d writeback", idx));
    endtask

    // Answers after 1 to 6 cycles
    initial begin : memory_model
        int unsigned lat;
        mem_resp  = 1'b0;
        mem_rline = '0;
        void'($urandom(32'hb328_0b7c));
        forever begin
            @(negedge clk);
            if (mem_read || mem_write) begin
                lat = $urandom_range(6, 1);
                repeat (lat) @(posedge clk);
                #1;
                if (mem_write) begin
                    write_count++;
                    check_line(mem_addr, mem_wline);
                    for (int i = 0; i < LINE_WORDS; i++) begin
                        mem_words[mem_addr + 4 * i] = mem_wline[WORD_BITS*i +: WORD_BITS];
                    end
                end else begin
                    read_count++;
                    mem_rline = memory_line(mem_addr);
                end
                mem_resp = 1'b1;
                @(posedge clk);
                #1;
                mem_resp = 1'b0;
            end
        end
    end

    initial begin : watchdog
        wait (cases_loaded);
        repeat (num_cases * 200 + 100) @(posedge clk);
        $display("Timeout: %0d cases did not finish in time", num_cases);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : main
        int                   fd;
        int                   code;
        string                text;
        logic [3:0]           f_op;
        logic [WORD_BITS-1:0] f_addr;
        logic [WORD_BITS-1:0] f_wdata;
        logic [3:0]           f_mask;
        logic [WORD_BITS-1:0] f_exp;
        logic [1:0]           f_traffic;
        clk         = 1'b0;
        rst_n       = 1'b0;
        cpu_read    = 1'b0;
        cpu_write   = 1'b0;
        cpu_addr    = '0;
        cpu_wdata   = '0;
        cpu_wmask   = '0;
        n_checks    = 0;
        n_errors    = 0;
        read_count  = 0;
        write_count = 0;

        fd = $fopen("dv/cache_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the cases file dv/cache_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(text, fd);
                if (code == 0 || text.len() < 2 || text.getc(0) == "#") begin
                    continue;
                end
                code = $sscanf(text, "%h %h %h %h %h %h",
                               f_op, f_addr, f_wdata, f_mask, f_exp, f_traffic);
                if (code != 6) begin
                    $display("Malformed line in the cases file: %s", text);
                    n_errors++;
                    continue;
                end
                case_op.push_back(f_op);
                case_addr.push_back(f_addr);
                case_wdata.push_back(f_wdata);
                case_mask.push_back(f_mask);
                case_exp.push_back(f_exp);
                case_traffic.push_back(f_traffic);
            end
            $fclose(fd);
        end
        num_cases = case_op.size();
        if (num_cases == 0) begin
            $display("No cases were read, nothing was tested");
            n_errors++;
        end
        cases_loaded = 1'b1;

        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Outputs quiet until the first request
        repeat (2) begin
            @(negedge clk);
            check_flag(cpu_resp, 1'b0, "cpu_resp after reset");
            check_flag(mem_read, 1'b0, "mem_read after reset");
            check_flag(mem_write, 1'b0, "mem_write after reset");
        end

        for (int i = 0; i < num_cases; i++) begin
            run_case(i);
        end

        $display("%0d cases, %0d checks, %0d errors", num_cases, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : cache_tb

//--- run_sim.sh
#!/usr/bin/env bash
# Build the cache testbench with Verilator, run it and scan the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module cache_tb -o cache_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/cache_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1

//--- sources.f
design/cache_types.sv
design/cache_addr_pkg.sv
design/plru_tree.sv
design/cache_arrays.sv
design/cache_control.sv
design/cache_logic.sv
design/cache_top.sv
dv/cache_asserts.sv
dv/cache_tb.sv
